// File: sim/fetch_unit_chk.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_chk import fetch_pkg::*; (
  input wire logic        clock,
  input wire logic        reset,
  input wire logic        redirect_valid,
  input wire fetch_out_t  out,
  input wire logic        inst_valid,
  input wire logic        ready,
  input wire logic        inst_addr_misaligned,
  input wire logic [31:0] fetch_pc,
  input wire ar_chan_t    ar,
  input wire logic        arvalid,
  input wire logic        arready
);

  int failures = 0;

  // ----------------------------------------
  // Read address channel.
  // ----------------------------------------

  ar_idle_after_reset: assert property (@(posedge clock) reset |=> !arvalid)
    else begin
      $error("arvalid high in the cycle after reset");
      failures++;
    end

  // Request held until the slave takes it.
  ar_held_until_ready: assert property (@(posedge clock) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(ar))
    else begin
      $error("read address request dropped or changed before arready");
      failures++;
    end

  // ----------------------------------------
  // Decode side.
  // ----------------------------------------

  // Only a redirect may drop the held beat.
  beat_held_on_stall: assert property (@(posedge clock) disable iff (reset)
    inst_valid && !ready && !redirect_valid |=> inst_valid && $stable(out))
    else begin
      $error("output beat changed while decode stalled");
      failures++;
    end

  trap_only_misaligned: assert property (@(posedge clock) disable iff (reset)
    inst_addr_misaligned |-> fetch_pc[1:0] != 2'b00)
    else begin
      $error("misaligned trap raised for an aligned fetch_pc");
      failures++;
    end

endmodule

bind fetch_unit fetch_unit_chk chk (.*);

`default_nettype wire

// File: sim/tb_fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module tb_fetch_unit import fetch_pkg::*; ();

  localparam logic [31:0] base = `FETCH_RESET_PC;

  logic        clock = 1'b0;
  logic        reset = 1'b1;
  logic        redirect_valid = 1'b0;
  logic [31:0] redirect_pc = '0;
  logic        clear_cache = 1'b0;
  logic        ready = 1'b0;
  logic        arready = 1'b0;
  r_beat_t     r = '0;
  logic        rvalid = 1'b0;
  fetch_out_t  out;
  logic        inst_valid;
  logic        inst_addr_misaligned;
  logic [31:0] fetch_pc;
  ar_chan_t    ar;
  logic        arvalid;
  logic        rready;

  integer      seed = 10;
  logic [31:0] rand_bits = '0;
  int          errors = 0;
  int          timeouts = 0;
  int          beats = 0;
  int          limit = 0;
  int          ar_count = 0;
  logic [31:0] exp_pc = base;
  logic        taken;
  logic        busy = 1'b0;
  logic [31:0] burst_addr = '0;
  int          beat_index = 0;
  logic [31:4] cached_line [4];
  logic [3:0]  cached_valid = '0;

  fetch_unit uut (.*);

  always #20 clock = ~clock;

  // Random draw shared by the memory model and decode side.
  always @(posedge clock) rand_bits <= $random(seed);

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return addr ^ 32'h5A5A_0000;
  endfunction

  task automatic check_that(input logic ok, input string what);
    assert (ok) else begin
      errors++;
      $display("ERROR at %0t ns: %s", $time, what);
    end
  endtask

  // ----------------------------------------
  // Burst memory model.
  // ----------------------------------------

  always @(posedge clock) begin
    if (reset) begin
      arready      <= 1'b0;
      rvalid       <= 1'b0;
      busy         <= 1'b0;
      cached_valid <= '0;
    end else begin
      arready <= rand_bits[0];
      if (clear_cache) begin
        cached_valid <= '0;
      end
      if (arvalid && arready) begin
        check_that(ar.addr[3:0] == 4'h0 && ar.len == 8'd3,
                   $sformatf("burst at %h with len %0d is not one line", ar.addr, ar.len));
        // Index of a 16-byte line in a four-line cache.
        check_that(!(cached_valid[ar.addr[5:4]] && cached_line[ar.addr[5:4]] == ar.addr[31:4]),
                   $sformatf("refill of line %h while it is still cached", ar.addr));
        cached_valid[ar.addr[5:4]] <= 1'b1;
        cached_line[ar.addr[5:4]]  <= ar.addr[31:4];
        burst_addr <= ar.addr;
        beat_index <= 0;
        busy       <= 1'b1;
        ar_count   <= ar_count + 1;
      end
      if (busy) begin
        if (rvalid && rready) begin
          rvalid     <= 1'b0;
          beat_index <= beat_index + 1;
          if (beat_index == 3) begin
            busy <= 1'b0;
          end
        end else if (!rvalid && rand_bits[1]) begin
          rvalid <= 1'b1;
          r      <= '{data: mem_word(burst_addr + beat_index * 4), last: beat_index == 3};
        end
      end
    end
  end

  // ----------------------------------------
  // Decode side and scoreboard.
  // ----------------------------------------

  // Ready stays low once the beat limit is reached.
  always @(posedge clock) begin
    if (reset) begin
      ready <= 1'b0;
    end else begin
      taken = inst_valid && ready;
      if (taken) begin
        check_that(out.pc == exp_pc && out.inst == mem_word(exp_pc),
                   $sformatf("beat pc %h inst %h, expected pc %h inst %h",
                             out.pc, out.inst, exp_pc, mem_word(exp_pc)));
        exp_pc = exp_pc + 32'd4;
        beats <= beats + 1;
      end
      if (redirect_valid) begin
        exp_pc = redirect_pc;
      end
      ready <= (beats + (taken ? 1 : 0) < limit) && (rand_bits[3:2] != 2'b00);
    end
  end

  task automatic wait_beats(input int target);
    int cycles;
    cycles = 0;
    while (beats < target && cycles < 3000) begin
      @(posedge clock);
      cycles++;
    end
    if (beats < target) begin
      timeouts++;
      $display("Timed out at %0t ns with %0d of %0d beats delivered", $time, beats, target);
    end
  endtask

  task automatic wait_trap();
    int cycles;
    cycles = 0;
    while (!inst_addr_misaligned && cycles < 50) begin
      @(posedge clock);
      cycles++;
    end
    if (!inst_addr_misaligned) begin
      timeouts++;
      $display("Timed out at %0t ns waiting for the misaligned fetch trap", $time);
    end
  endtask

  task automatic send_redirect(input logic [31:0] target);
    redirect_valid <= 1'b1;
    redirect_pc    <= target;
    @(posedge clock);
    redirect_valid <= 1'b0;
  endtask

  // ----------------------------------------
  // Test sequence.
  // ----------------------------------------

  initial begin
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    check_that(!inst_valid && !arvalid && !rready && !inst_addr_misaligned
               && fetch_pc == base, "outputs not idle after reset");

    // Straight run through four lines.
    limit <= 14;
    wait_beats(14);
    check_that(ar_count == 4, $sformatf("%0d bursts for four lines", ar_count));

    // Stall with the next beat held, then take just that one.
    repeat (8) @(posedge clock);
    check_that(inst_valid && out.pc == base + 32'h38, "no beat held while decode stalls");
    limit <= 15;
    wait_beats(15);

    // Back into cached lines.
    send_redirect(base + 32'h10);
    limit <= 26;
    wait_beats(26);
    check_that(ar_count == 4, $sformatf("%0d bursts after refetch of cached lines", ar_count));

    // Flush, then one burst for the refetched line.
    clear_cache <= 1'b1;
    @(posedge clock);
    clear_cache <= 1'b0;
    send_redirect(base + 32'h20);
    limit <= 29;
    wait_beats(29);
    check_that(ar_count == 5, $sformatf("%0d bursts after cache flush", ar_count));

    send_redirect(base + 32'h400);
    limit <= 34;
    wait_beats(34);
    check_that(ar_count == 7, $sformatf("%0d bursts after new target", ar_count));

    // Misaligned target traps until an aligned redirect.
    send_redirect(base + 32'h402);
    limit <= 38;
    wait_trap();
    repeat (20) @(posedge clock);
    check_that(inst_addr_misaligned && fetch_pc == base + 32'h402,
               $sformatf("trap state lost, fetch_pc %h", fetch_pc));
    check_that(beats == 34 && !inst_valid && ar_count == 7, "fetch activity during trap");
    send_redirect(base + 32'h400);
    wait_beats(38);
    check_that(!inst_addr_misaligned && ar_count == 7, "fetch not restored after trap");
    repeat (4) @(posedge clock);

    $display("Closing report: %0d errors, %0d timeouts, %0d assertion failures",
             errors, timeouts, uut.chk.failures);
    if (errors == 0 && timeouts == 0 && uut.chk.failures == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/fetch_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_control import fetch_pkg::*; (
  input  wire logic        clock,
  input  wire logic        reset,
  input  wire lookup_t     lookup,
  input  wire logic        fill_valid,
  output logic             refill_start,
  output logic [31:0]      pc,
  output fetch_out_t       out,
  output logic             inst_valid,
  input  wire logic        ready,
  input  wire logic        redirect_valid,
  input  wire logic [31:0] redirect_pc,
  output logic             inst_addr_misaligned,
  output logic [31:0]      fetch_pc
);

  fetch_state_t state;

  logic refill_pending;
  logic can_accept;
  logic take_hit;
  logic misaligned_target;

  // ----------------------------------------
  // Lookup decisions.
  // ----------------------------------------

  // Output register is free or drains this cycle.
  assign can_accept = !inst_valid || ready;

  assign misaligned_target = redirect_pc[1:0] != 2'b00;

  assign take_hit = state == fetch_lookup && !redirect_valid && can_accept && lookup.hit;

  assign refill_start = state == fetch_lookup && !redirect_valid && can_accept
                        && !lookup.hit;

  assign inst_addr_misaligned = state == fetch_trap;
  assign fetch_pc             = pc;

  // ----------------------------------------
  // Refill tracking.
  // ----------------------------------------

  // Survives a redirect, so a new lookup waits for the burst in flight.
  always_ff @(posedge clock) begin
    if (reset) begin
      refill_pending <= 1'b0;
    end else if (refill_start) begin
      refill_pending <= 1'b1;
    end else if (fill_valid) begin
      refill_pending <= 1'b0;
    end
  end

  // ----------------------------------------
  // PC and fetch FSM.
  // ----------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= fetch_lookup;
      pc         <= `FETCH_RESET_PC;
      inst_valid <= 1'b0;
    end else if (redirect_valid) begin
      // Redirect wins over everything.
      pc         <= redirect_pc;
      inst_valid <= 1'b0;
      if (misaligned_target) begin
        state <= fetch_trap;
      end else if (refill_pending && !fill_valid) begin
        state <= fetch_refill;
      end else begin
        state <= fetch_lookup;
      end
    end else begin
      if (inst_valid && ready) begin
        inst_valid <= 1'b0;
      end
      case (state)
        fetch_lookup: begin
          if (take_hit) begin
            inst_valid <= 1'b1;
            pc         <= pc + 32'd4;
          end else if (refill_start) begin
            state <= fetch_refill;
          end
        end
        fetch_refill: begin
          // Same PC again once the line is in.
          if (fill_valid) begin
            state <= fetch_lookup;
          end
        end
        fetch_trap: begin
          state <= fetch_trap;
        end
        default: begin
          state <= fetch_lookup;
        end
      endcase
    end
  end

  // ----------------------------------------
  // Output beat toward decode.
  // ----------------------------------------

  // Held unchanged while decode stalls.
  always_ff @(posedge clock) begin
    if (take_hit) begin
      out.pc   <= pc;
      out.inst <= lookup.word;
    end
  end

endmodule

`default_nettype wire

// File: source/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// ----------------------------------------
// Cache geometry.
// ----------------------------------------

// Byte offset inside a 16-byte line.
`define FETCH_OFFSET_BITS 4

// Four lines.
`define FETCH_INDEX_BITS 2

`define FETCH_TAG_BITS (32 - `FETCH_OFFSET_BITS - `FETCH_INDEX_BITS)

`define FETCH_LINE_BITS 128

// ----------------------------------------
// Refill and reset.
// ----------------------------------------

`define FETCH_BURST_BEATS 4

`define FETCH_RESET_PC 32'h8000_0000

`endif

// File: source/fetch_pkg.sv
`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

  // ----------------------------------------
  // State encodings.
  // ----------------------------------------

  typedef enum logic [1:0] {
    fetch_lookup,
    fetch_refill,
    fetch_trap
  } fetch_state_t;

  typedef enum logic [1:0] {
    refill_idle,
    refill_address,
    refill_data
  } refill_state_t;

  // ----------------------------------------
  // Payloads between blocks.
  // ----------------------------------------

  // Cache answer for the current PC.
  typedef struct packed {
    logic        hit;
    logic [31:0] word;
  } lookup_t;

  // Completed line, written by the cache when valid.
  typedef struct packed {
    logic                          valid;
    logic [`FETCH_INDEX_BITS-1:0]  index;
    logic [`FETCH_TAG_BITS-1:0]    tag;
    logic [`FETCH_LINE_BITS-1:0]   data;
  } line_fill_t;

  // Beat toward decode.
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
  } fetch_out_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [7:0]  len;
  } ar_chan_t;

  typedef struct packed {
    logic [31:0] data;
    logic        last;
  } r_beat_t;

endpackage

`default_nettype wire

// File: source/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import fetch_pkg::*; (
  input  wire logic        clock,
  input  wire logic        reset,

  // Back end.
  input  wire logic        redirect_valid,
  input  wire logic [31:0] redirect_pc,
  input  wire logic        clear_cache,

  // Decode.
  output fetch_out_t       out,
  output logic             inst_valid,
  input  wire logic        ready,
  output logic             inst_addr_misaligned,
  output logic [31:0]      fetch_pc,

  // AXI read channels.
  output ar_chan_t         ar,
  output logic             arvalid,
  input  wire logic        arready,
  input  wire r_beat_t     r,
  input  wire logic        rvalid,
  output logic             rready
);

  lookup_t     lookup;
  line_fill_t  fill;
  logic        refill_start;
  logic [31:0] pc;

  icache_array u_icache_array (
    .clock       (clock),
    .reset       (reset),
    .pc          (pc),
    .clear_cache (clear_cache),
    .fill        (fill),
    .lookup      (lookup)
  );

  line_refill u_line_refill (
    .clock        (clock),
    .reset        (reset),
    .refill_start (refill_start),
    .refill_pc    (pc),
    .ar           (ar),
    .arvalid      (arvalid),
    .arready      (arready),
    .r            (r),
    .rvalid       (rvalid),
    .rready       (rready),
    .fill         (fill)
  );

  fetch_control u_fetch_control (
    .clock                (clock),
    .reset                (reset),
    .lookup               (lookup),
    .fill_valid           (fill.valid),
    .refill_start         (refill_start),
    .pc                   (pc),
    .out                  (out),
    .inst_valid           (inst_valid),
    .ready                (ready),
    .redirect_valid       (redirect_valid),
    .redirect_pc          (redirect_pc),
    .inst_addr_misaligned (inst_addr_misaligned),
    .fetch_pc             (fetch_pc)
  );

endmodule

`default_nettype wire

// File: source/icache_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module icache_array import fetch_pkg::*; (
  input  wire logic        clock,
  input  wire logic        reset,
  input  wire logic [31:0] pc,
  input  wire logic        clear_cache,
  input  wire line_fill_t  fill,
  output lookup_t          lookup
);

  localparam int line_count = 1 << `FETCH_INDEX_BITS;

  logic [`FETCH_TAG_BITS-1:0]   tag_mem  [line_count];
  logic [`FETCH_LINE_BITS-1:0]  data_mem [line_count];
  logic [line_count-1:0]        valid_bits;

  logic [`FETCH_INDEX_BITS-1:0] index;
  logic [`FETCH_TAG_BITS-1:0]   pc_tag;
  logic [`FETCH_LINE_BITS-1:0]  line;

  // ----------------------------------------
  // Address split.
  // ----------------------------------------

  assign index  = pc[`FETCH_OFFSET_BITS +: `FETCH_INDEX_BITS];
  assign pc_tag = pc[31 -: `FETCH_TAG_BITS];
  assign line   = data_mem[index];

  // ----------------------------------------
  // Valid bits.
  // ----------------------------------------

  // A fill in the clearing cycle still lands.
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_bits <= '0;
    end else begin
      if (clear_cache) begin
        valid_bits <= '0;
      end
      if (fill.valid) begin
        valid_bits[fill.index] <= 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Tag and data storage.
  // ----------------------------------------

  always_ff @(posedge clock) begin
    if (fill.valid) begin
      tag_mem[fill.index]  <= fill.tag;
      data_mem[fill.index] <= fill.data;
    end
  end

  // ----------------------------------------
  // Hit detection and word select.
  // ----------------------------------------

  always_comb begin
    lookup.hit  = valid_bits[index] && (tag_mem[index] == pc_tag);
    // Word 0 sits in the low bits of the line.
    lookup.word = line[{pc[`FETCH_OFFSET_BITS-1:2], 5'b00000} +: 32];
  end

endmodule

`default_nettype wire

// File: source/line_refill.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module line_refill import fetch_pkg::*; (
  input  wire logic        clock,
  input  wire logic        reset,
  input  wire logic        refill_start,
  input  wire logic [31:0] refill_pc,
  output ar_chan_t         ar,
  output logic             arvalid,
  input  wire logic        arready,
  input  wire r_beat_t     r,
  input  wire logic        rvalid,
  output logic             rready,
  output line_fill_t       fill
);

  refill_state_t state;

  logic [31:0]                 line_addr;
  logic [`FETCH_LINE_BITS-1:0] line_data;
  logic                        beat_taken;

  assign beat_taken = rvalid && rready;

  // Whole-line burst, aligned to the line.
  assign ar = '{addr: line_addr, len: 8'(`FETCH_BURST_BEATS - 1)};

  // ----------------------------------------
  // Burst FSM.
  // ----------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= refill_idle;
      arvalid <= 1'b0;
      rready  <= 1'b0;
    end else begin
      case (state)
        refill_idle: begin
          if (refill_start) begin
            arvalid <= 1'b1;
            state   <= refill_address;
          end
        end
        refill_address: begin
          if (arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
            state   <= refill_data;
          end
        end
        refill_data: begin
          if (beat_taken && r.last) begin
            rready <= 1'b0;
            state  <= refill_idle;
          end
        end
        default: begin
          arvalid <= 1'b0;
          rready  <= 1'b0;
          state   <= refill_idle;
        end
      endcase
    end
  end

  // ----------------------------------------
  // Address latch and beat shifter.
  // ----------------------------------------

  always_ff @(posedge clock) begin
    if (state == refill_idle && refill_start) begin
      line_addr <= {refill_pc[31:`FETCH_OFFSET_BITS], {`FETCH_OFFSET_BITS{1'b0}}};
    end
    // New beats enter at the top, so the first one ends up lowest.
    if (beat_taken) begin
      line_data <= {r.data, line_data[`FETCH_LINE_BITS-1:32]};
    end
  end

  // Line goes out on the last beat itself.
  always_comb begin
    fill.valid = beat_taken && r.last;
    fill.index = line_addr[`FETCH_OFFSET_BITS +: `FETCH_INDEX_BITS];
    fill.tag   = line_addr[31 -: `FETCH_TAG_BITS];
    fill.data  = {r.data, line_data[`FETCH_LINE_BITS-1:32]};
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+source
source/fetch_pkg.sv
source/icache_array.sv
source/line_refill.sv
source/fetch_control.sv
source/fetch_unit.sv
sim/fetch_unit_chk.sv
sim/tb_fetch_unit.sv
